//--- hw/esp_link_cfg.svh
`ifndef ESP_LINK_CFG_SVH
`define ESP_LINK_CFG_SVH

// reply to get_cookie, lets the coprocessor find the FPGA
`define ESP_COOKIE 8'hAF

// firmware version returned by get_version
// packed as {major, minor}
`define ESP_VERSION_MAJOR 3'd0
`define ESP_VERSION_MINOR 5'd3

// screen color out of reset, white
`define ESP_COLOR_RESET 24'hFFFFFF

// flops on each SPI pin
// the last two stages also serve for edge detection
`define ESP_SYNC_STAGES 3

// keyboard matrix rows, 8 bits each
`define ESP_KEYB_ROWS 8

`endif

//--- hw/esp_link_pkg.sv
package esp_link_pkg;

  // command opcodes sent by the coprocessor
  // numbering matches the full command set
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_screen_color = 8'd17,
    send_keyb        = 8'd19,
    set_led          = 8'd26,
    set_esp_status   = 8'd32
  } opcode_e;

  // one completed command, param[0] is the first byte after the opcode
  typedef struct packed {
    opcode_e         opcode;
    logic [2:0][7:0] param;
  } cmd_t;

  // screen color, one byte per channel
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // board RGB LED
  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_t;

  // coprocessor status flags, esp_ready is bit 0
  typedef struct packed {
    logic [3:0] spare;
    logic       sd_mounted;
    logic       smb_mounted;
    logic       wifi_up;
    logic       esp_ready;
  } esp_status_t;

endpackage

//--- hw/spi_byte_port.sv
`include "esp_link_cfg.svh"

module spi_byte_port (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic [7:0] reply,
  input  logic       reply_load,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int sync_n = `ESP_SYNC_STAGES;

  logic [sync_n-1:0] sck_sync;
  logic [sync_n-1:0] cs_sync;
  logic [sync_n-1:0] mosi_sync;
  logic [2:0]        bit_cnt;
  logic [7:0]        tx_reg;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_active;
  logic              mosi_bit;

  // edges seen between the last two synchronizer stages
  assign sck_rise  = sck_sync[sync_n-2] & ~sck_sync[sync_n-1];
  assign sck_fall  = ~sck_sync[sync_n-2] & sck_sync[sync_n-1];
  assign cs_active = ~cs_sync[sync_n-1];
  assign mosi_bit  = mosi_sync[sync_n-1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[sync_n-2:0], sck};
      cs_sync   <= {cs_sync[sync_n-2:0], cs_n};
      mosi_sync <= {mosi_sync[sync_n-2:0], mosi};
    end
  end

  // receive side, msb first, sampled on rising sck
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= 3'd0;
      rx_byte  <= 8'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        rx_byte <= {rx_byte[6:0], mosi_bit};
        if (bit_cnt == 3'd7) begin
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // transmit side
  // the falling edge that closes a byte (count back at 0) does not shift,
  // so a reply loaded while sck is still high keeps its bit 7
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_reg <= 8'd0;
    end else if (reply_load) begin
      tx_reg <= reply;
    end else if (cs_active && sck_fall && bit_cnt != 3'd0) begin
      tx_reg <= {tx_reg[6:0], 1'b0};
    end
  end

  // reply bit 7 shows up in the same cycle as the load
  assign miso = cs_active ? (reply_load ? reply[7] : tx_reg[7]) : 1'b0;

endmodule

//--- hw/cmd_decoder.sv
module cmd_decoder (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  logic [7:0]         rx_byte,
  input  logic               rx_valid,
  output esp_link_pkg::cmd_t cmd,
  output logic               cmd_valid
);

  typedef enum logic {
    idle,
    read_params
  } state_e;

  state_e     state;
  logic [1:0] params_left;
  logic [1:0] param_idx;
  logic [1:0] new_count;

  // parameter bytes that follow each opcode
  function automatic logic [1:0] param_count(input logic [7:0] opcode);
    case (opcode)
      esp_link_pkg::set_led:          param_count = 2'd1;
      esp_link_pkg::set_esp_status:   param_count = 2'd1;
      esp_link_pkg::send_keyb:        param_count = 2'd2;
      esp_link_pkg::set_screen_color: param_count = 2'd3;
      // get_cookie, get_version and unknown opcodes
      default:                        param_count = 2'd0;
    endcase
  endfunction

  assign new_count = param_count(rx_byte);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state       <= idle;
      params_left <= 2'd0;
      param_idx   <= 2'd0;
      cmd         <= '0;
      cmd_valid   <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            cmd.opcode  <= esp_link_pkg::opcode_e'(rx_byte);
            param_idx   <= 2'd0;
            params_left <= new_count;
            // no parameters, issue right away
            if (new_count == 2'd0) begin
              cmd_valid <= 1'b1;
            end else begin
              state <= read_params;
            end
          end
          read_params: begin
            cmd.param[param_idx] <= rx_byte;
            param_idx            <= param_idx + 2'd1;
            params_left          <= params_left - 2'd1;
            // last parameter lands together with the strobe
            if (params_left == 2'd1) begin
              cmd_valid <= 1'b1;
              state     <= idle;
            end
          end
        endcase
      end
    end
  end

endmodule

//--- hw/host_regs.sv
`include "esp_link_cfg.svh"

module host_regs (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  esp_link_pkg::cmd_t        cmd,
  input  logic                      cmd_valid,
  output esp_link_pkg::led_t        led,
  output esp_link_pkg::esp_status_t esp_status,
  output esp_link_pkg::rgb_t        screen_color,
  output logic                      key_pressed,
  output logic                      cmd_error,
  output logic [7:0]                reply,
  output logic                      reply_load
);

  localparam int row_w = $clog2(`ESP_KEYB_ROWS);

  // keyboard matrix, one byte per row
  logic [`ESP_KEYB_ROWS-1:0][7:0] keyb_rows;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led          <= '0;
      esp_status   <= '0;
      screen_color <= `ESP_COLOR_RESET;
      keyb_rows    <= '0;
      cmd_error    <= 1'b0;
      reply        <= 8'd0;
      reply_load   <= 1'b0;
    end else begin
      reply_load <= 1'b0;
      if (cmd_valid) begin
        case (cmd.opcode)
          esp_link_pkg::get_cookie: begin
            reply      <= `ESP_COOKIE;
            reply_load <= 1'b1;
          end
          esp_link_pkg::get_version: begin
            reply      <= {`ESP_VERSION_MAJOR, `ESP_VERSION_MINOR};
            reply_load <= 1'b1;
          end
          esp_link_pkg::set_led: begin
            led.red   <= cmd.param[0][0];
            led.green <= cmd.param[0][1];
            led.blue  <= cmd.param[0][2];
          end
          esp_link_pkg::set_esp_status: begin
            esp_status <= esp_link_pkg::esp_status_t'(cmd.param[0]);
          end
          esp_link_pkg::send_keyb: begin
            // row select from the low bits of param 0
            keyb_rows[cmd.param[0][row_w-1:0]] <= cmd.param[1];
          end
          esp_link_pkg::set_screen_color: begin
            screen_color.red   <= cmd.param[0];
            screen_color.green <= cmd.param[1];
            screen_color.blue  <= cmd.param[2];
          end
          default: begin
            // sticky until reset
            cmd_error <= 1'b1;
          end
        endcase
      end
    end
  end

  // any key down in any row
  assign key_pressed = |keyb_rows;

endmodule

//--- hw/esp_link_top.sv
module esp_link_top (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      sck,
  input  logic                      cs_n,
  input  logic                      mosi,
  output logic                      miso,
  output esp_link_pkg::led_t        led,
  output esp_link_pkg::esp_status_t esp_status,
  output esp_link_pkg::rgb_t        screen_color,
  output logic                      key_pressed,
  output logic                      cmd_error
);

  logic [7:0]         rx_byte;
  logic               rx_valid;
  esp_link_pkg::cmd_t cmd;
  logic               cmd_valid;
  logic [7:0]         reply;
  logic               reply_load;

  // SPI pins to bytes and back
  spi_byte_port u_port (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .reply          (reply),
    .reply_load     (reply_load),
    .miso           (miso),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  cmd_decoder u_dec (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid)
  );

  host_regs u_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .key_pressed    (key_pressed),
    .cmd_error      (cmd_error),
    .reply          (reply),
    .reply_load     (reply_load)
  );

endmodule

//--- dv/esp_link_checker.sv
module esp_link_checker;
  timeunit 1ns;
  timeprecision 1ps;

  int checks = 0;
  int mismatches = 0;

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // one round of compares per finished command
  always @(tb_esp_link.check_ev) begin
    compare("led", 32'(tb_esp_link.u_dut.led), 32'(tb_esp_link.exp_m.led));
    compare("esp_status", 32'(tb_esp_link.u_dut.esp_status),
            32'(tb_esp_link.exp_m.status));
    compare("screen_color", 32'(tb_esp_link.u_dut.screen_color),
            32'(tb_esp_link.exp_m.color));
    compare("key_pressed", 32'(tb_esp_link.u_dut.key_pressed),
            32'(tb_esp_link.exp_m.key));
    compare("cmd_error", 32'(tb_esp_link.u_dut.cmd_error),
            32'(tb_esp_link.exp_m.err));
    // reply byte only exists after get_cookie and get_version
    if (tb_esp_link.check_reply) begin
      compare("reply", 32'(tb_esp_link.read_reply), 32'(tb_esp_link.exp_m.reply));
    end
  end

endmodule

//--- dv/tb_esp_link.sv
module tb_esp_link;
  timeunit 1ns;
  timeprecision 1ps;

  // expected DUT outputs plus the last reply byte read back
  typedef struct packed {
    esp_link_pkg::led_t        led;
    esp_link_pkg::esp_status_t status;
    esp_link_pkg::rgb_t        color;
    logic [7:0][7:0]           rows;
    logic                      key;
    logic                      err;
    logic [7:0]                reply;
  } model_t;

  logic clk = 1'b0;
  logic cass_out_sel_n;
  logic sck;
  logic cs_n;
  logic mosi;
  logic miso;
  esp_link_pkg::led_t        led;
  esp_link_pkg::esp_status_t esp_status;
  esp_link_pkg::rgb_t        screen_color;
  logic key_pressed;
  logic cmd_error;

  model_t     exp_m;
  logic       check_reply;
  logic [7:0] read_reply;
  integer     seed;
  int         timeouts;
  bit         done;
  event       check_ev;

  always #20 clk = ~clk;

  esp_link_top u_dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .key_pressed    (key_pressed),
    .cmd_error      (cmd_error)
  );

  esp_link_checker u_check ();

  function automatic model_t expected_state(input model_t m, input logic [7:0] op,
                                            input logic [7:0] p0, input logic [7:0] p1,
                                            input logic [7:0] p2);
    case (op)
      8'd0:  m.reply = 8'hAF;
      // major 0 in the top 3 bits, minor 3 below
      8'd15: m.reply = {3'd0, 5'd3};
      8'd17: m.color = {p0, p1, p2};
      8'd19: m.rows[p0[2:0]] = p1;
      8'd26: begin
        m.led.red   = p0[0];
        m.led.green = p0[1];
        m.led.blue  = p0[2];
      end
      8'd32: m.status = p0;
      default: m.err = 1'b1;
    endcase
    m.key = |m.rows;
    return m;
  endfunction

  function automatic logic [7:0] rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // inputs change 2 ns after the rising clock edge
  task automatic wait_clks(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
    end
  endtask

  // SPI mode 0, msb first, miso sampled just before each rising sck
  task automatic send_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_clks(8);
      rx[i] = miso;
      sck = 1'b1;
      wait_clks(8);
      sck = 1'b0;
    end
    wait_clks(12);
  endtask

  task automatic run_command(input logic [7:0] op, input logic [7:0] p0, input logic [7:0] p1,
                             input logic [7:0] p2, input int n, input logic want_reply);
    logic [7:0] params [3];
    logic [7:0] rx;
    int i;
    params = '{p0, p1, p2};
    cs_n = 1'b0;
    wait_clks(8);
    send_byte(op, rx);
    for (i = 0; i < n; i++) begin
      send_byte(params[i], rx);
    end
    // dummy byte clocks the reply out
    if (want_reply) begin
      send_byte(8'h00, rx);
      read_reply = rx;
    end
    cs_n = 1'b1;
    wait_clks(20);
    exp_m = expected_state(exp_m, op, p0, p1, p2);
    check_reply = want_reply;
    ->check_ev;
  endtask

  task automatic report();
    $display("checks %0d, mismatches %0d, timeouts %0d",
             u_check.checks, u_check.mismatches, timeouts);
    if (u_check.mismatches == 0 && timeouts == 0 && u_check.checks > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    int k;
    cass_out_sel_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    check_reply = 1'b0;
    read_reply = 8'h00;
    seed = 32'h5747;
    timeouts = 0;
    done = 1'b0;
    exp_m = '0;
    exp_m.color = 24'hFFFFFF;
    wait_clks(8);
    cass_out_sel_n = 1'b1;
    wait_clks(4);
    ->check_ev;
    wait_clks(2);
    run_command(8'd0, 8'h00, 8'h00, 8'h00, 0, 1'b1);
    run_command(8'd15, 8'h00, 8'h00, 8'h00, 0, 1'b1);
    for (k = 0; k < 4; k++) begin
      a = rand_byte();
      b = rand_byte();
      run_command(8'd26, a, 8'h00, 8'h00, 1, 1'b0);
      run_command(8'd32, b, 8'h00, 8'h00, 1, 1'b0);
    end
    for (k = 0; k < 3; k++) begin
      a = rand_byte();
      b = rand_byte();
      c = rand_byte();
      run_command(8'd17, a, b, c, 3, 1'b0);
    end
    for (k = 0; k < 4; k++) begin
      a = rand_byte();
      b = rand_byte();
      if (b == 8'h00) begin
        b = 8'h01;
      end
      run_command(8'd19, a, b, 8'h00, 2, 1'b0);
    end
    // clear every row, key_pressed must drop
    for (k = 0; k < 8; k++) begin
      run_command(8'd19, k[7:0], 8'h00, 8'h00, 2, 1'b0);
    end
    run_command(8'd99, 8'h00, 8'h00, 8'h00, 0, 1'b0);
    a = rand_byte();
    // every LED flips so a lost set_led shows up
    a[2:0] = ~{exp_m.led.blue, exp_m.led.green, exp_m.led.red};
    run_command(8'd26, a, 8'h00, 8'h00, 1, 1'b0);
    wait_clks(2);
    done = 1'b1;
    report();
  end

  // watchdog on the whole run
  initial begin
    int cyc;
    for (cyc = 0; cyc < 200000 && !done; cyc++) begin
      @(posedge clk);
    end
    if (!done) begin
      $display("timeout: stimulus did not complete within %0d clock cycles", cyc);
      timeouts++;
      report();
    end
  end

endmodule

//--- tb.f
+incdir+hw
hw/esp_link_pkg.sv
hw/spi_byte_port.sv
hw/cmd_decoder.sv
hw/host_regs.sv
hw/esp_link_top.sv
dv/esp_link_checker.sv
dv/tb_esp_link.sv

//--- run.sh
#!/bin/sh
# build and run the esp_link testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module tb_esp_link -o sim_esp_link
./obj_dir/sim_esp_link > sim.log
cat sim.log
if grep -q "^Verification passed$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
